/* source/sched_config.svh */
// Scheduler configuration with bank geometry, address widths, queue depth and DRAM latencies
`ifndef SCHED_CONFIG_SVH
`define SCHED_CONFIG_SVH

// Bank geometry
`define SCHED_BANK_GROUPS     2
`define SCHED_BANKS_PER_GROUP 2
`define SCHED_BANKS           (`SCHED_BANK_GROUPS * `SCHED_BANKS_PER_GROUP)

// Address and data widths
`define SCHED_ROW_BITS  8
`define SCHED_COL_BITS  4
`define SCHED_DATA_BITS 64

`define SCHED_QUEUE_DEPTH 4     // Entries in every per-bank FIFO

// DRAM latencies in controller cycles
`define SCHED_ACT_LATENCY 8
`define SCHED_PRE_LATENCY 5

`define SCHED_STAMP_BITS 32     // Free-running cycle counter

`endif

/* source/sched_pkg.sv */
// Scheduler package with request, command, queue entry, bank status and lane offer types
`include "sched_config.svh"

package sched_pkg;

    localparam int BG_BITS       = $clog2(`SCHED_BANK_GROUPS);
    localparam int BA_BITS       = $clog2(`SCHED_BANKS_PER_GROUP);
    localparam int BANK_IDX_BITS = $clog2(`SCHED_BANKS);

    typedef enum logic [1:0] {
        CMD_READ      = 2'd0,
        CMD_WRITE     = 2'd1,
        CMD_ACTIVATE  = 2'd2,
        CMD_PRECHARGE = 2'd3
    } cmd_kind_t;

    typedef struct packed {
        logic [BG_BITS-1:0]          bank_group;
        logic [BA_BITS-1:0]          bank;
        logic [`SCHED_ROW_BITS-1:0]  row;
        logic [`SCHED_COL_BITS-1:0]  col;
        logic                        write;
        logic [`SCHED_DATA_BITS-1:0] data;
    } host_req_t;

    // Stamp is the cycle the entry entered its current pending stage
    typedef struct packed {
        host_req_t                    req;
        logic [`SCHED_STAMP_BITS-1:0] stamp;
    } queue_entry_t;

    typedef struct packed {
        cmd_kind_t                   kind;
        logic [BG_BITS-1:0]          bank_group;
        logic [BA_BITS-1:0]          bank;
        logic [`SCHED_ROW_BITS-1:0]  row;
        logic [`SCHED_COL_BITS-1:0]  col;
        logic [`SCHED_DATA_BITS-1:0] data;
    } dram_cmd_t;

    typedef struct packed {
        logic [`SCHED_BANKS-1:0]                      idle;
        logic [`SCHED_BANKS-1:0]                      open;
        logic [`SCHED_BANKS-1:0]                      blocked;
        logic [`SCHED_BANKS-1:0][`SCHED_ROW_BITS-1:0] open_row;
    } bank_status_t;

    typedef struct packed {
        logic                       activate;
        logic                       precharge;
        logic [BANK_IDX_BITS-1:0]   bank;
        logic [`SCHED_ROW_BITS-1:0] row;
    } bank_op_t;

    typedef struct packed {
        logic         has_read;
        logic         has_write;
        logic         has_activate;
        logic         has_precharge;
        queue_entry_t read_top;
        queue_entry_t write_top;
        queue_entry_t act_top;
        queue_entry_t pre_top;
    } lane_offer_t;

endpackage

/* source/req_fifo.sv */
// Request FIFO, a circular buffer with a head pointer, a fill count and any payload type
`timescale 1ns/100ps

module req_fifo #(
    parameter int  DEPTH   = 4,
    parameter type entry_t = logic
) (
    input  logic   clk_in,
    input  logic   rst_in,
    input  logic   push,
    input  logic   pop,
    input  entry_t din,
    output entry_t dout,
    output logic   empty,
    output logic   full
);
    localparam int PTR_BITS = $clog2(DEPTH);

    entry_t              mem [DEPTH];
    logic [PTR_BITS-1:0] head;
    logic [PTR_BITS-1:0] tail;
    logic [PTR_BITS:0]   count;
    logic                do_push;
    logic                do_pop;

    assign do_push = push && !full;     // Dropped when full
    assign do_pop  = pop && !empty;
    assign tail    = PTR_BITS'(({1'b0, head} + count) % DEPTH);

    always_ff @(posedge clk_in) begin
        if (do_push) begin
            mem[tail] <= din;
        end
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            head  <= '0;
            count <= '0;
        end else begin
            if (do_pop) begin
                head <= (head == PTR_BITS'(DEPTH - 1)) ? '0 : head + 1'b1;
            end
            count <= count + (PTR_BITS + 1)'(do_push) - (PTR_BITS + 1)'(do_pop);
        end
    end

    assign dout  = mem[head];
    assign empty = (count == '0);
    assign full  = (count == (PTR_BITS + 1)'(DEPTH));

    // Nothing upstream holds off a push, so a full FIFO would lose a request
    no_push_when_full: assert property (@(posedge clk_in) disable iff (rst_in)
        push |-> !full)
        else $error("req_fifo: push while full, request lost");

    no_pop_when_empty: assert property (@(posedge clk_in) disable iff (rst_in)
        pop |-> !empty)
        else $error("req_fifo: pop while empty");

endmodule

/* source/stage_queue.sv */
// Stage queue, a ready FIFO feeding a pending FIFO that releases entries after a latency
`timescale 1ns/100ps
`include "sched_config.svh"

module stage_queue #(
    parameter int LATENCY = 1
) (
    input  logic                         clk_in,
    input  logic                         rst_in,
    input  logic                         push,
    input  sched_pkg::queue_entry_t      entry_in,
    input  logic                         take,
    input  logic                         promote_ok,
    input  logic [`SCHED_STAMP_BITS-1:0] cycle_count,
    output sched_pkg::queue_entry_t      top,
    output logic                         has_top,
    output logic                         promote,
    output sched_pkg::queue_entry_t      promoted
);
    import sched_pkg::*;

    queue_entry_t stamped;
    logic         ready_empty;
    logic         pending_empty;
    logic         expired;

    req_fifo #(
        .DEPTH   (`SCHED_QUEUE_DEPTH),
        .entry_t (queue_entry_t)
    ) u_ready (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .push   (push),
        .pop    (take),
        .din    (entry_in),
        .dout   (top),
        .empty  (ready_empty),
        .full   ()
    );

    // Entry issued from the ready side waits here for its latency
    assign stamped = '{req: top.req, stamp: cycle_count};

    req_fifo #(
        .DEPTH   (`SCHED_QUEUE_DEPTH),
        .entry_t (queue_entry_t)
    ) u_pending (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .push   (take),
        .pop    (promote),
        .din    (stamped),
        .dout   (promoted),
        .empty  (pending_empty),
        .full   ()
    );

    assign has_top = !ready_empty;
    assign expired = !pending_empty &&
                     (cycle_count - promoted.stamp >= `SCHED_STAMP_BITS'(LATENCY));
    assign promote = expired && promote_ok;    // Held while a host request owns the target

endmodule

/* source/bank_tracker.sv */
// Bank state tracker with open row, open flag and blocking countdown for every bank
`timescale 1ns/100ps
`include "sched_config.svh"

module bank_tracker (
    input  logic                    clk_in,
    input  logic                    rst_in,
    input  sched_pkg::bank_op_t     op,
    output sched_pkg::bank_status_t status
);
    import sched_pkg::*;

    localparam int MAX_LAT  = (`SCHED_ACT_LATENCY > `SCHED_PRE_LATENCY) ?
                              `SCHED_ACT_LATENCY : `SCHED_PRE_LATENCY;
    localparam int CNT_BITS = $clog2(MAX_LAT + 1);

    logic [`SCHED_BANKS-1:0]                      open_q;
    logic [`SCHED_BANKS-1:0]                      blocked;
    logic [`SCHED_BANKS-1:0][CNT_BITS-1:0]        count;
    logic [`SCHED_BANKS-1:0][`SCHED_ROW_BITS-1:0] row_q;

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            open_q <= '0;
            count  <= '0;
        end else begin
            for (int b = 0; b < `SCHED_BANKS; b++) begin
                if (op.activate && op.bank == BANK_IDX_BITS'(b)) begin
                    open_q[b] <= 1'b1;
                    count[b]  <= CNT_BITS'(`SCHED_ACT_LATENCY);
                end else if (op.precharge && op.bank == BANK_IDX_BITS'(b)) begin
                    open_q[b] <= 1'b0;
                    count[b]  <= CNT_BITS'(`SCHED_PRE_LATENCY);
                end else if (blocked[b]) begin
                    count[b] <= count[b] - 1'b1;
                end
            end
        end
    end

    // Row is only meaningful while the open flag is set
    always_ff @(posedge clk_in) begin
        if (op.activate) begin
            row_q[op.bank] <= op.row;
        end
    end

    always_comb begin
        for (int b = 0; b < `SCHED_BANKS; b++) begin
            blocked[b] = (count[b] != '0);
        end
    end

    assign status.open     = open_q;
    assign status.blocked  = blocked;
    assign status.idle     = ~open_q & ~blocked;   // Precharged and settled
    assign status.open_row = row_q;

    // The arbiter must respect the block it caused on an earlier cycle
    op_to_free_bank: assert property (@(posedge clk_in) disable iff (rst_in)
        (op.activate || op.precharge) |-> !blocked[op.bank])
        else $error("bank_tracker: op to blocked bank %0d", op.bank);

endmodule

/* source/bank_lane.sv */
// Bank lane with one bank's precharge, activation, read and write queues and their chaining
`timescale 1ns/100ps
`include "sched_config.svh"

module bank_lane (
    input  logic                         clk_in,
    input  logic                         rst_in,
    input  logic                         enqueue,
    input  sched_pkg::host_req_t         req,
    input  logic                         bank_open,
    input  logic                         bank_idle,
    input  logic [`SCHED_ROW_BITS-1:0]   open_row,
    input  logic [`SCHED_STAMP_BITS-1:0] cycle_count,
    input  logic                         take_read,
    input  logic                         take_write,
    input  logic                         take_act,
    input  logic                         take_pre,
    output sched_pkg::lane_offer_t       offer
);
    import sched_pkg::*;

    queue_entry_t new_entry;
    queue_entry_t pre_promoted;
    queue_entry_t act_promoted;
    logic         row_hit;
    logic         to_act, to_read, to_write, to_pre;
    logic         pre_promote, act_promote;
    logic         read_empty, write_empty;

    assign new_entry = '{req: req, stamp: cycle_count};

    // Placement follows the bank state seen this cycle
    assign row_hit  = bank_open && (open_row == req.row);
    assign to_act   = enqueue && bank_idle;
    assign to_write = enqueue && row_hit && req.write;
    assign to_read  = enqueue && row_hit && !req.write;
    assign to_pre   = enqueue && !bank_idle && !row_hit;

    stage_queue #(.LATENCY(`SCHED_PRE_LATENCY)) u_pre (
        .clk_in, .rst_in, .cycle_count,
        .push       (to_pre),
        .entry_in   (new_entry),
        .take       (take_pre),
        .promote_ok (!to_act),                  // Host request into activation wins
        .top        (offer.pre_top),
        .has_top    (offer.has_precharge),
        .promote    (pre_promote),
        .promoted   (pre_promoted)
    );

    stage_queue #(.LATENCY(`SCHED_ACT_LATENCY)) u_act (
        .clk_in, .rst_in, .cycle_count,
        .push       (to_act || pre_promote),
        .entry_in   (to_act ? new_entry : pre_promoted),
        .take       (take_act),
        .promote_ok (act_promoted.req.write ? !to_write : !to_read),
        .top        (offer.act_top),
        .has_top    (offer.has_activate),
        .promote    (act_promote),
        .promoted   (act_promoted)
    );

    req_fifo #(.DEPTH(`SCHED_QUEUE_DEPTH), .entry_t(queue_entry_t)) u_read (
        .clk_in, .rst_in,
        .push  (to_read || (act_promote && !act_promoted.req.write)),
        .pop   (take_read),
        .din   (to_read ? new_entry : act_promoted),
        .dout  (offer.read_top),
        .empty (read_empty),
        .full  ()
    );

    req_fifo #(.DEPTH(`SCHED_QUEUE_DEPTH), .entry_t(queue_entry_t)) u_write (
        .clk_in, .rst_in,
        .push  (to_write || (act_promote && act_promoted.req.write)),
        .pop   (take_write),
        .din   (to_write ? new_entry : act_promoted),
        .dout  (offer.write_top),
        .empty (write_empty),
        .full  ()
    );

    assign offer.has_read  = !read_empty;
    assign offer.has_write = !write_empty;

endmodule

/* source/cmd_arbiter.sv */
// Command arbiter, one fixed-priority DRAM command per cycle with a registered output
`timescale 1ns/100ps
`include "sched_config.svh"

module cmd_arbiter (
    input  logic                                      clk_in,
    input  logic                                      rst_in,
    input  sched_pkg::lane_offer_t [`SCHED_BANKS-1:0] offers,
    input  sched_pkg::bank_status_t                   status,
    input  logic                                      cmd_ready,
    output logic [`SCHED_BANKS-1:0]                   take_read,
    output logic [`SCHED_BANKS-1:0]                   take_write,
    output logic [`SCHED_BANKS-1:0]                   take_act,
    output logic [`SCHED_BANKS-1:0]                   take_pre,
    output sched_pkg::bank_op_t                       op,
    output logic                                      cmd_valid,
    output sched_pkg::dram_cmd_t                      cmd
);
    import sched_pkg::*;

    logic [`SCHED_BANKS-1:0]  access_ok, free;
    logic [`SCHED_BANKS-1:0]  wr_elig, rd_elig, act_elig, pre_elig;
    logic [`SCHED_BANKS-1:0]  sel;
    logic [BANK_IDX_BITS-1:0] chosen_bank;
    queue_entry_t             chosen;
    cmd_kind_t                kind;

    assign free      = ~status.blocked;
    assign access_ok = status.open & free;

    for (genvar b = 0; b < `SCHED_BANKS; b++) begin : g_elig
        assign wr_elig[b]  = offers[b].has_write && access_ok[b] &&
                             offers[b].write_top.req.row == status.open_row[b];
        assign rd_elig[b]  = offers[b].has_read && access_ok[b] &&
                             offers[b].read_top.req.row == status.open_row[b];
        assign act_elig[b] = offers[b].has_activate && free[b];
        assign pre_elig[b] = offers[b].has_precharge && free[b];
    end

    always_comb begin
        take_write = '0;
        take_read  = '0;
        take_act   = '0;
        take_pre   = '0;
        kind       = CMD_READ;
        if (cmd_ready) begin
            // Write, read, activate, precharge; lowest bank wins within a class
            if (|wr_elig) begin
                take_write = wr_elig & (~wr_elig + 1'b1);
                kind       = CMD_WRITE;
            end else if (|rd_elig) begin
                take_read = rd_elig & (~rd_elig + 1'b1);
                kind      = CMD_READ;
            end else if (|act_elig) begin
                take_act = act_elig & (~act_elig + 1'b1);
                kind     = CMD_ACTIVATE;
            end else if (|pre_elig) begin
                take_pre = pre_elig & (~pre_elig + 1'b1);
                kind     = CMD_PRECHARGE;
            end
        end
        sel         = take_write | take_read | take_act | take_pre;
        chosen      = '0;
        chosen_bank = '0;
        for (int b = 0; b < `SCHED_BANKS; b++) begin
            if (sel[b]) chosen_bank = BANK_IDX_BITS'(b);
            if (take_write[b]) chosen = offers[b].write_top;
            if (take_read[b]) chosen = offers[b].read_top;
            if (take_act[b]) chosen = offers[b].act_top;
            if (take_pre[b]) chosen = offers[b].pre_top;
        end
    end

    // Tracker sees the op in the same cycle as the decision
    assign op = '{activate: |take_act, precharge: |take_pre,
                  bank: chosen_bank, row: chosen.req.row};

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) cmd_valid <= 1'b0;
        else        cmd_valid <= |sel;
    end

    always_ff @(posedge clk_in) begin
        if (|sel) begin
            cmd.kind       <= kind;
            cmd.bank_group <= chosen.req.bank_group;
            cmd.bank       <= chosen.req.bank;
            cmd.row        <= chosen.req.row;
            cmd.col        <= chosen.req.col;
            cmd.data       <= (kind == CMD_WRITE) ? chosen.req.data : '0;  // Writes only
        end
    end

endmodule

/* source/request_scheduler.sv */
// Request scheduler top with cycle counter, per-bank lanes, bank tracker and command arbiter
`timescale 1ns/100ps
`include "sched_config.svh"

module request_scheduler (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic                 req_valid,
    input  sched_pkg::host_req_t req,
    input  logic                 cmd_ready,
    output logic                 cmd_valid,
    output sched_pkg::dram_cmd_t cmd
);
    import sched_pkg::*;

    logic [`SCHED_STAMP_BITS-1:0]        cycle_count;
    logic [BANK_IDX_BITS-1:0]            req_bank;
    logic [`SCHED_BANKS-1:0]             enqueue;
    logic [`SCHED_BANKS-1:0]             take_read, take_write, take_act, take_pre;
    lane_offer_t [`SCHED_BANKS-1:0]      offers;
    bank_status_t                        status;
    bank_op_t                            op;

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) cycle_count <= '0;
        else        cycle_count <= cycle_count + 1'b1;
    end

    // Flat bank index, group major
    assign req_bank = BANK_IDX_BITS'(req.bank_group * `SCHED_BANKS_PER_GROUP + req.bank);
    assign enqueue  = {{(`SCHED_BANKS - 1){1'b0}}, req_valid} << req_bank;

    for (genvar b = 0; b < `SCHED_BANKS; b++) begin : g_lane
        bank_lane u_lane (
            .clk_in, .rst_in, .req, .cycle_count,
            .enqueue    (enqueue[b]),
            .bank_open  (status.open[b]),
            .bank_idle  (status.idle[b]),
            .open_row   (status.open_row[b]),
            .take_read  (take_read[b]),
            .take_write (take_write[b]),
            .take_act   (take_act[b]),
            .take_pre   (take_pre[b]),
            .offer      (offers[b])
        );
    end

    bank_tracker u_tracker (.clk_in, .rst_in, .op, .status);

    cmd_arbiter u_arbiter (
        .clk_in, .rst_in, .offers, .status, .cmd_ready,
        .take_read, .take_write, .take_act, .take_pre,
        .op, .cmd_valid, .cmd
    );

endmodule

/* tests/sched_checker.sv */
// Command checker that compares every DUT command beat with the expected command sequence
`timescale 1ns/100ps

module sched_checker (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic                 cmd_ready,
    input  logic                 cmd_valid,
    input  sched_pkg::dram_cmd_t cmd,
    input  logic                 exp_push,
    input  sched_pkg::dram_cmd_t exp_cmd,
    output int                   beats,
    output int                   errors
);
    import sched_pkg::*;

    dram_cmd_t expected [$];
    dram_cmd_t want;
    logic      ready_q     = 1'b1;  // cmd_ready as seen at the previous edge
    int        beat_count  = 0;
    int        error_count = 0;

    assign beats  = beat_count;
    assign errors = error_count;

    task automatic check_field(input string name, input logic [63:0] exp_val,
                               input logic [63:0] got_val);
        if (exp_val !== got_val) begin
            $display("FAILED t=%0t %s expected %0h got %0h", $time, name, exp_val, got_val);
            error_count++;
        end
    endtask

    always @(posedge clk_in) begin
        if (exp_push) expected.push_back(exp_cmd);
        if (rst_in) begin
            if (cmd_valid !== 1'b0) begin
                $display("A command was issued during reset at t=%0t", $time);
                error_count++;
            end
        end else if (cmd_valid === 1'b1) begin
            // Registered output, so a stall shows one edge later
            if (!ready_q) begin
                $display("FAILED t=%0t cmd_valid expected 0 got 1", $time);
                error_count++;
            end
            if (expected.size() == 0) begin
                $display("A command arrived at t=%0t with no command outstanding", $time);
                error_count++;
            end else begin
                want = expected.pop_front();
                check_field("cmd.kind", 64'(want.kind), 64'(cmd.kind));
                check_field("cmd.bank_group", 64'(want.bank_group), 64'(cmd.bank_group));
                check_field("cmd.bank", 64'(want.bank), 64'(cmd.bank));
                check_field("cmd.row", 64'(want.row), 64'(cmd.row));
                check_field("cmd.col", 64'(want.col), 64'(cmd.col));
                check_field("cmd.data", want.data, cmd.data);
                beat_count++;
            end
        end else if (cmd_valid !== 1'b0) begin
            $display("cmd_valid is unknown at t=%0t", $time);
            error_count++;
        end
        ready_q <= cmd_ready;
    end

endmodule

/* tests/tb_request_scheduler.sv */
// Request scheduler testbench with a stimulus table, a bank state model and a watchdog
`timescale 1ns/100ps
`include "sched_config.svh"

module tb_request_scheduler;
    import sched_pkg::*;

    typedef struct packed {
        host_req_t  req;
        logic [7:0] gap;        // Idle cycles once the request has completed
        logic [7:0] stall;      // Cycles of cmd_ready low after the request
    } stim_row_t;

    localparam int          NUM_ROWS  = 12;
    localparam logic [15:0] LFSR_TAPS = 16'hB400;

    logic      clk_in, rst_in, req_valid, cmd_ready, cmd_valid, exp_push;
    host_req_t req;
    dram_cmd_t cmd, exp_cmd;
    stim_row_t rows [NUM_ROWS];
    logic [15:0] lfsr = 16'd71;
    int        limit_cycles = 0;
    int        pushed = 0;
    int        beats, errors;
    logic                       model_open [`SCHED_BANKS];
    logic [`SCHED_ROW_BITS-1:0] model_row  [`SCHED_BANKS];

    request_scheduler dut (.clk_in, .rst_in, .req_valid, .req, .cmd_ready, .cmd_valid, .cmd);

    sched_checker u_checker (
        .clk_in, .rst_in, .cmd_ready, .cmd_valid, .cmd, .exp_push, .exp_cmd, .beats, .errors
    );

    always #50 clk_in = ~clk_in;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[62:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic stim_row_t make_row(input int bg, input int ba, input int row,
                                           input int col, input logic wr, input int gap);
        stim_row_t r;
        r                = '0;
        r.req.bank_group = BG_BITS'(bg);
        r.req.bank       = BA_BITS'(ba);
        r.req.row        = `SCHED_ROW_BITS'(row);
        r.req.col        = `SCHED_COL_BITS'(col);
        r.req.write      = wr;
        r.gap            = 8'(gap);
        return r;
    endfunction

    // Commands carry the request fields and carry data only on writes
    function automatic dram_cmd_t make_cmd(input cmd_kind_t kind, input host_req_t r);
        dram_cmd_t c;
        c.kind       = kind;
        c.bank_group = r.bank_group;
        c.bank       = r.bank;
        c.row        = r.row;
        c.col        = r.col;
        c.data       = (kind == CMD_WRITE) ? r.data : '0;
        return c;
    endfunction

    task automatic push_expected(input cmd_kind_t kind, input host_req_t r);
        exp_cmd  = make_cmd(kind, r);
        exp_push = 1'b1;
        pushed++;
        @(posedge clk_in);
        #10;
        exp_push = 1'b0;
    endtask

    task automatic expect_commands(input host_req_t r);
        int        b;
        cmd_kind_t access;
        b      = r.bank_group * `SCHED_BANKS_PER_GROUP + r.bank;
        access = r.write ? CMD_WRITE : CMD_READ;
        if (model_open[b] && model_row[b] != r.row) push_expected(CMD_PRECHARGE, r);
        if (!model_open[b] || model_row[b] != r.row) push_expected(CMD_ACTIVATE, r);
        push_expected(access, r);
        model_open[b] = 1'b1;       // Row stays open after the access
        model_row[b]  = r.row;
    endtask

    task automatic send_request(input stim_row_t s);
        req       = s.req;
        req_valid = 1'b1;
        @(posedge clk_in);
        #10;
        req_valid = 1'b0;
        if (s.stall != 0) begin
            cmd_ready = 1'b0;
            repeat (s.stall) begin
                @(posedge clk_in);
                #10;
            end
            cmd_ready = 1'b1;
        end
    endtask

    initial begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge clk_in);
        $display("Timeout after %0d cycles, expected commands never arrived", limit_cycles);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        logic [63:0] bits;
        int          total;
        clk_in    = 1'b0;
        rst_in    = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        cmd_ready = 1'b1;
        exp_push  = 1'b0;
        exp_cmd   = '0;
        total     = 0;
        for (int b = 0; b < `SCHED_BANKS; b++) begin
            model_open[b] = 1'b0;
            model_row[b]  = '0;
        end
        rows[0]  = make_row(0, 0, 'h10, 'h1, 1'b1, 4);    // Idle bank
        rows[1]  = make_row(0, 0, 'h10, 'h2, 1'b0, 3);    // Row hit
        rows[2]  = make_row(0, 0, 'h22, 'h3, 1'b1, 5);    // Row miss
        rows[3]  = make_row(1, 1, 'h05, 'h4, 1'b0, 2);
        rows[4]  = make_row(0, 1, 'h33, 'h5, 1'b1, 4);
        rows[5]  = make_row(1, 0, 'h44, 'h6, 1'b0, 3);
        rows[6]  = make_row(1, 1, 'h05, 'h7, 1'b1, 2);
        rows[7]  = make_row(0, 1, 'h34, 'h8, 1'b0, 5);
        rows[8]  = make_row(1, 0, 'h44, 'h9, 1'b1, 3);
        rows[9]  = make_row(0, 0, 'h22, 'ha, 1'b0, 4);
        rows[10] = make_row(1, 0, 'h80, 'hb, 1'b1, 2);
        rows[11] = make_row(0, 0, 'hff, 'hf, 1'b0, 4);
        for (int i = 0; i < NUM_ROWS; i++) begin
            draw_bits(64, bits);
            rows[i].req.data = bits;
            draw_bits(4, bits);
            rows[i].stall = 8'(bits);
            total += rows[i].gap + rows[i].stall;
        end
        limit_cycles = total + 40 * NUM_ROWS;

        #1;
        rst_in = 1'b1;
        repeat (2) @(posedge clk_in);
        #10;
        rst_in = 1'b0;
        repeat (2) begin
            @(posedge clk_in);
            #10;
        end

        for (int i = 0; i < NUM_ROWS; i++) begin
            expect_commands(rows[i].req);
            send_request(rows[i]);
            while (beats < pushed) begin    // All commands of this request seen
                @(posedge clk_in);
                #10;
            end
            repeat (rows[i].gap) begin
                @(posedge clk_in);
                #10;
            end
        end
        repeat (10) begin
            @(posedge clk_in);
            #10;
        end

        $display("Summary: %0d requests, %0d of %0d commands checked, %0d errors",
                 NUM_ROWS, beats, pushed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+source
source/sched_pkg.sv
source/req_fifo.sv
source/stage_queue.sv
source/bank_tracker.sv
source/bank_lane.sv
source/cmd_arbiter.sv
source/request_scheduler.sv
tests/sched_checker.sv
tests/tb_request_scheduler.sv

/* Bender.yml */
package:
  name: request_scheduler

export_include_dirs:
  - source

sources:
  - files:
      - source/sched_pkg.sv
      - source/req_fifo.sv
      - source/stage_queue.sv
      - source/bank_tracker.sv
      - source/bank_lane.sv
      - source/cmd_arbiter.sv
      - source/request_scheduler.sv
  - target: test
    files:
      - tests/sched_checker.sv
      - tests/tb_request_scheduler.sv
